// ==== osc_params.svh ====
// widths are fixed here and not overridable; addresses decode 7 bits, no bus error response
`ifndef OSC_PARAMS_SVH
`define OSC_PARAMS_SVH

// datapath widths
`define OSC_DW  16
`define OSC_CW  31
`define OSC_EW  5
`define OSC_DCW 17
`define OSC_DSW 4

// register bus
`define OSC_AW  7

// register byte offsets
`define OSC_A_CTL  7'h00
`define OSC_A_STR  7'h04
`define OSC_A_STP  7'h08
`define OSC_A_TRG  7'h0c
`define OSC_A_IEN  7'h10
`define OSC_A_IST  7'h14
`define OSC_A_PRE  7'h20
`define OSC_A_PST  7'h24
`define OSC_A_SPRE 7'h28
`define OSC_A_SPST 7'h2c
`define OSC_A_POS  7'h30
`define OSC_A_NEG  7'h34
`define OSC_A_EDG  7'h38
`define OSC_A_HLD  7'h3c
`define OSC_A_DEC  7'h40
`define OSC_A_SHR  7'h44
`define OSC_A_AVG  7'h48

`endif

// ==== osc_pkg.sv ====
// shared types for the scope; the command view is only meaningful at the control offset
package osc_pkg;

  `include "osc_params.svh"

  // one signed sample
  typedef logic signed [`OSC_DW-1:0] sample_t;

  // software strobes, bit 0 is reset
  typedef struct packed {
    logic [27:0] rsv;
    logic        trg;
    logic        stp;
    logic        str;
    logic        rst;
  } osc_cmd_t;

  // write data word seen two ways
  //   raw for plain config registers
  //   cmd when the control register is written
  typedef union packed {
    logic [31:0] raw;
    osc_cmd_t    cmd;
  } osc_word_u;

endpackage

// ==== osc_if.sv ====
// bundles inside the design only; no clock in the interfaces, all users share the bus clock
`timescale 1ns/1ps
`include "osc_params.svh"

////////////////////
// sample stream
////////////////////

interface osc_stream_if import osc_pkg::*; ();
  sample_t data;
  logic    last;
  logic    valid;
  logic    ready;

  // source holds data and valid until ready
  modport src (output data, last, valid, input ready);
  modport snk (input data, last, valid, output ready);
endinterface

////////////////////
// sequencer control
////////////////////

interface osc_acq_if;
  // masked event strobes
  logic               start;
  logic               stop;
  logic               trig;
  // counter limits
  logic [`OSC_CW-1:0] cfg_pre;
  logic [`OSC_CW-1:0] cfg_pst;
  // status back to the register set
  logic               sts_str;
  logic               sts_trg;
  logic               sts_stp;
  logic [`OSC_CW-1:0] sts_pre;
  logic [`OSC_CW-1:0] sts_pst;

  modport ctl (output start, stop, trig, cfg_pre, cfg_pst,
               input  sts_str, sts_trg, sts_stp, sts_pre, sts_pst);
  modport acq (input  start, stop, trig, cfg_pre, cfg_pst,
               output sts_str, sts_trg, sts_stp, sts_pre, sts_pst);
endinterface

////////////////////
// level trigger config
////////////////////

interface osc_trig_if import osc_pkg::*; ();
  sample_t            cfg_pos;
  sample_t            cfg_neg;
  logic               cfg_edg;
  logic [`OSC_CW-1:0] cfg_hld;

  modport ctl (output cfg_pos, cfg_neg, cfg_edg, cfg_hld);
  modport edg (input  cfg_pos, cfg_neg, cfg_edg, cfg_hld);
endinterface

// ==== osc_regset.sv ====
// unmapped offsets read zero and ignore writes; a clear write to status wins over a new set
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_regset import osc_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  // register bus
  input  logic                wen,
  input  logic                ren,
  input  logic [`OSC_AW-1:0]  addr,
  input  logic [31:0]         wdata,
  output logic [31:0]         rdata,
  output logic                ack,
  // event matrix
  input  logic [`OSC_EW-1:0]  evn_ext,
  output logic                evn_str,
  output logic                evn_stp,
  output logic                evn_trg,
  // datapath control
  output logic                sw_rst,
  osc_acq_if.ctl              acq,
  osc_trig_if.ctl             trig,
  output logic                cfg_avg,
  output logic [`OSC_DCW-1:0] cfg_dec,
  output logic [`OSC_DSW-1:0] cfg_shr,
  output logic                irq
);

  osc_word_u          w;
  // event select masks
  logic [`OSC_EW-1:0] cfg_str;
  logic [`OSC_EW-1:0] cfg_stp;
  logic [`OSC_EW-1:0] cfg_trg;
  // interrupt enable and status, {trig, stop, start}
  logic [2:0]         irq_ena;
  logic [2:0]         irq_sts;

  assign w = wdata;

  // single cycle ack
  always_ff @(posedge bus) begin
    if (ctl_rst) ack <= 1'b0;
    else         ack <= wen | ren;
  end

  ////////////////////
  // config writes
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      cfg_str      <= '0;
      cfg_stp      <= '0;
      cfg_trg      <= '0;
      irq_ena      <= '0;
      acq.cfg_pre  <= '0;
      acq.cfg_pst  <= '0;
      trig.cfg_pos <= '0;
      trig.cfg_neg <= '0;
      trig.cfg_edg <= 1'b0;
      trig.cfg_hld <= '0;
      cfg_dec      <= '0;
      cfg_shr      <= '0;
      cfg_avg      <= 1'b0;
    end else if (wen) begin
      case (addr)
        `OSC_A_STR: cfg_str      <= w.raw[`OSC_EW-1:0];
        `OSC_A_STP: cfg_stp      <= w.raw[`OSC_EW-1:0];
        `OSC_A_TRG: cfg_trg      <= w.raw[`OSC_EW-1:0];
        `OSC_A_IEN: irq_ena      <= w.raw[2:0];
        `OSC_A_PRE: acq.cfg_pre  <= w.raw[`OSC_CW-1:0];
        `OSC_A_PST: acq.cfg_pst  <= w.raw[`OSC_CW-1:0];
        `OSC_A_POS: trig.cfg_pos <= sample_t'(w.raw[`OSC_DW-1:0]);
        `OSC_A_NEG: trig.cfg_neg <= sample_t'(w.raw[`OSC_DW-1:0]);
        `OSC_A_EDG: trig.cfg_edg <= w.raw[0];
        `OSC_A_HLD: trig.cfg_hld <= w.raw[`OSC_CW-1:0];
        `OSC_A_DEC: cfg_dec      <= w.raw[`OSC_DCW-1:0];
        `OSC_A_SHR: cfg_shr      <= w.raw[`OSC_DSW-1:0];
        `OSC_A_AVG: cfg_avg      <= w.raw[0];
        default: ;
      endcase
    end
  end

  // control strobes, one cycle after the write
  always_ff @(posedge bus) begin
    if (ctl_rst) begin
      sw_rst  <= 1'b0;
      evn_str <= 1'b0;
      evn_stp <= 1'b0;
      evn_trg <= 1'b0;
    end else begin
      sw_rst  <= wen && (addr == `OSC_A_CTL) && w.cmd.rst;
      evn_str <= wen && (addr == `OSC_A_CTL) && w.cmd.str;
      evn_stp <= wen && (addr == `OSC_A_CTL) && w.cmd.stp;
      evn_trg <= wen && (addr == `OSC_A_CTL) && w.cmd.trg;
    end
  end

  // event matrix, any selected source fires
  assign acq.start = |(evn_ext & cfg_str);
  assign acq.stop  = |(evn_ext & cfg_stp);
  assign acq.trig  = |(evn_ext & cfg_trg);

  ////////////////////
  // interrupts
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      irq_sts <= '0;
    end else if (wen && (addr == `OSC_A_IST)) begin
      // write one to clear
      irq_sts <= irq_sts & ~w.raw[2:0];
    end else begin
      irq_sts <= irq_sts | {acq.trig, acq.stop, acq.start};
    end
  end

  always_ff @(posedge bus) begin
    if (ctl_rst) irq <= 1'b0;
    else         irq <= |(irq_sts & irq_ena);
  end

  // read mux, lands together with ack
  always_ff @(posedge bus) begin
    case (addr)
      `OSC_A_CTL:  rdata <= {28'd0, acq.sts_trg, acq.sts_stp, acq.sts_str, 1'b0};
      `OSC_A_STR:  rdata <= 32'(cfg_str);
      `OSC_A_STP:  rdata <= 32'(cfg_stp);
      `OSC_A_TRG:  rdata <= 32'(cfg_trg);
      `OSC_A_IEN:  rdata <= 32'(irq_ena);
      `OSC_A_IST:  rdata <= 32'(irq_sts);
      `OSC_A_PRE:  rdata <= 32'(acq.cfg_pre);
      `OSC_A_PST:  rdata <= 32'(acq.cfg_pst);
      `OSC_A_SPRE: rdata <= 32'(acq.sts_pre);
      `OSC_A_SPST: rdata <= 32'(acq.sts_pst);
      // levels read back zero extended
      `OSC_A_POS:  rdata <= {{(32-`OSC_DW){1'b0}}, trig.cfg_pos};
      `OSC_A_NEG:  rdata <= {{(32-`OSC_DW){1'b0}}, trig.cfg_neg};
      `OSC_A_EDG:  rdata <= 32'(trig.cfg_edg);
      `OSC_A_HLD:  rdata <= 32'(trig.cfg_hld);
      `OSC_A_DEC:  rdata <= 32'(cfg_dec);
      `OSC_A_SHR:  rdata <= 32'(cfg_shr);
      `OSC_A_AVG:  rdata <= 32'(cfg_avg);
      default:     rdata <= '0;
    endcase
  end

endmodule

// ==== osc_decimator.sv ====
// sum is 33 bits, enough for the largest group; result is truncated after the shift
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_decimator import osc_pkg::*; (
  input  logic                bus,
  input  logic                ctl_rst,
  input  logic                sw_rst,
  input  logic                cfg_avg,
  input  logic [`OSC_DCW-1:0] cfg_dec,
  input  logic [`OSC_DSW-1:0] cfg_shr,
  osc_stream_if.snk           sti,
  osc_stream_if.src           sto
);

  logic [`OSC_DCW-1:0] cnt;
  logic signed [32:0]  sum;
  logic signed [32:0]  sum_nxt;
  logic signed [32:0]  avg;
  logic                xfer_i;
  logic                grp_end;

  // one slot in flight, next group keeps accumulating
  assign sti.ready = ~sto.valid | sto.ready;
  assign xfer_i    = sti.valid & sti.ready;
  assign grp_end   = cnt >= cfg_dec;

  // running sum, already zero at the start of a group
  assign sum_nxt = sum + 33'(sti.data);
  assign avg     = sum_nxt >>> cfg_shr;

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      cnt <= '0;
      sum <= '0;
    end else if (xfer_i) begin
      if (grp_end) begin
        cnt <= '0;
        sum <= '0;
      end else begin
        cnt <= cnt + 1'b1;
        sum <= sum_nxt;
      end
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      sto.valid <= 1'b0;
    end else if (xfer_i && grp_end) begin
      sto.valid <= 1'b1;
    end else if (sto.ready) begin
      sto.valid <= 1'b0;
    end
  end

  // payload, last follows the group's final sample
  always_ff @(posedge bus) begin
    if (xfer_i && grp_end) begin
      sto.data <= cfg_avg ? sample_t'(avg) : sti.data;
      sto.last <= sti.last;
    end
  end

endmodule

// ==== osc_edge.sv ====
// levels compare signed; hold-off counts accepted samples only, not clock cycles
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_edge (
  input  logic      bus,
  input  logic      ctl_rst,
  input  logic      sw_rst,
  osc_trig_if.edg   cfg,
  osc_stream_if.snk sti,
  osc_stream_if.src sto,
  output logic      evn_lvl
);

  logic               xfer;
  logic               armed;
  logic               hit_arm;
  logic               hit_fire;
  logic [`OSC_CW-1:0] hld_cnt;

  // monitor only, stream untouched
  assign sto.data  = sti.data;
  assign sto.last  = sti.last;
  assign sto.valid = sti.valid;
  assign sti.ready = sto.ready;

  assign xfer = sti.valid & sti.ready;

  // rising: arm low, fire high
  // falling: levels swap roles
  assign hit_arm  = cfg.cfg_edg ? (sti.data >= cfg.cfg_pos) : (sti.data <= cfg.cfg_neg);
  assign hit_fire = cfg.cfg_edg ? (sti.data <= cfg.cfg_neg) : (sti.data >= cfg.cfg_pos);

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      armed   <= 1'b0;
      hld_cnt <= '0;
      evn_lvl <= 1'b0;
    end else begin
      evn_lvl <= 1'b0;
      if (xfer) begin
        if (hld_cnt != '0) begin
          // hold-off window, ignore the sample
          hld_cnt <= hld_cnt - 1'b1;
        end else if (armed && hit_fire) begin
          armed   <= 1'b0;
          evn_lvl <= 1'b1;
          hld_cnt <= cfg.cfg_hld;
        end else if (hit_arm) begin
          armed <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== osc_acq.sv ====
// input last is not forwarded; the sequencer marks the final post-trigger sample itself
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_acq (
  input  logic      bus,
  input  logic      ctl_rst,
  input  logic      sw_rst,
  osc_acq_if.acq    ctl,
  osc_stream_if.snk sti,
  osc_stream_if.src sto,
  output logic      evn_lst
);

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_PRE  = 2'd1;
  localparam logic [1:0] S_ARM  = 2'd2;
  localparam logic [1:0] S_POST = 2'd3;

  logic [1:0] state;
  logic       run;
  logic       xfer;
  logic       lst;

  assign run = state != S_IDLE;

  // pass while running, drain and drop while idle
  assign sto.data  = sti.data;
  assign sto.valid = run & sti.valid;
  assign sti.ready = run ? sto.ready : 1'b1;

  assign xfer = sto.valid & sto.ready;
  // post count reached on this sample
  assign lst      = (state == S_POST) && (ctl.sts_pst == ctl.cfg_pst);
  assign sto.last = lst;

  assign ctl.sts_str = run;

  ////////////////////
  // sequencer FSM
  ////////////////////

  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) begin
      state       <= S_IDLE;
      ctl.sts_trg <= 1'b0;
      ctl.sts_stp <= 1'b0;
      ctl.sts_pre <= '0;
      ctl.sts_pst <= '0;
    end else if (run && ctl.stop) begin
      // abort, no last
      state       <= S_IDLE;
      ctl.sts_stp <= 1'b1;
    end else if (ctl.start) begin
      state       <= S_PRE;
      ctl.sts_trg <= 1'b0;
      ctl.sts_stp <= 1'b0;
      ctl.sts_pre <= '0;
      ctl.sts_pst <= '0;
    end else begin
      case (state)
        S_PRE: begin
          if (ctl.sts_pre >= ctl.cfg_pre) state <= S_ARM;
          else if (xfer)                  ctl.sts_pre <= ctl.sts_pre + 1'b1;
        end
        S_ARM: begin
          if (xfer) ctl.sts_pre <= ctl.sts_pre + 1'b1;
          // early triggers never get here
          if (ctl.trig) begin
            state       <= S_POST;
            ctl.sts_trg <= 1'b1;
          end
        end
        S_POST: begin
          if (xfer && lst) begin
            state       <= S_IDLE;
            ctl.sts_stp <= 1'b1;
          end else if (xfer) begin
            ctl.sts_pst <= ctl.sts_pst + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // pulse after the final transfer
  always_ff @(posedge bus) begin
    if (ctl_rst || sw_rst) evn_lst <= 1'b0;
    else                   evn_lst <= xfer & lst;
  end

endmodule

// ==== osc_top.sv ====
// single channel, no correction filter; event outputs must be looped to evn_ext outside
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_top import osc_pkg::*; (
  input  logic               bus,
  input  logic               ctl_rst,
  // register bus
  input  logic               bus_wen,
  input  logic               bus_ren,
  input  logic [`OSC_AW-1:0] bus_addr,
  input  logic [31:0]        bus_wdata,
  output logic [31:0]        bus_rdata,
  output logic               bus_ack,
  // input stream
  input  sample_t            sti_data,
  input  logic               sti_last,
  input  logic               sti_valid,
  output logic               sti_ready,
  // output stream
  output sample_t            sto_data,
  output logic               sto_last,
  output logic               sto_valid,
  input  logic               sto_ready,
  // events
  input  logic [`OSC_EW-1:0] evn_ext,
  output logic               evn_str,
  output logic               evn_stp,
  output logic               evn_trg,
  output logic               evn_lvl,
  output logic               evn_lst,
  output logic               irq
);

  logic                sw_rst;
  logic                cfg_avg;
  logic [`OSC_DCW-1:0] cfg_dec;
  logic [`OSC_DSW-1:0] cfg_shr;

  // chain: input, decimator, edge, sequencer
  osc_stream_if st_in  ();
  osc_stream_if st_dec ();
  osc_stream_if st_edg ();
  osc_stream_if st_out ();
  osc_acq_if    acq_if ();
  osc_trig_if   trg_if ();

  assign st_in.data   = sti_data;
  assign st_in.last   = sti_last;
  assign st_in.valid  = sti_valid;
  assign sti_ready    = st_in.ready;
  assign sto_data     = st_out.data;
  assign sto_last     = st_out.last;
  assign sto_valid    = st_out.valid;
  assign st_out.ready = sto_ready;

  osc_regset u_regset (
    .bus, .ctl_rst,
    .wen (bus_wen), .ren (bus_ren), .addr (bus_addr),
    .wdata (bus_wdata), .rdata (bus_rdata), .ack (bus_ack),
    .evn_ext, .evn_str, .evn_stp, .evn_trg,
    .sw_rst, .acq (acq_if), .trig (trg_if),
    .cfg_avg, .cfg_dec, .cfg_shr, .irq
  );

  osc_decimator u_dec (
    .bus, .ctl_rst, .sw_rst, .cfg_avg, .cfg_dec, .cfg_shr,
    .sti (st_in), .sto (st_dec)
  );

  osc_edge u_edge (
    .bus, .ctl_rst, .sw_rst, .cfg (trg_if),
    .sti (st_dec), .sto (st_edg), .evn_lvl
  );

  osc_acq u_acq (
    .bus, .ctl_rst, .sw_rst, .ctl (acq_if),
    .sti (st_edg), .sto (st_out), .evn_lst
  );

endmodule

// ==== osc_assertions.sv ====
// bound to osc_top; assumes a single bus access at a time, so ack never stays high two cycles
`timescale 1ns/1ps

module osc_assertions (
  input logic        bus,
  input logic        ctl_rst,
  input logic        bus_ack,
  input logic [15:0] sto_data,
  input logic        sto_valid,
  input logic        sto_ready,
  input logic        sto_last,
  input logic        evn_lst
);

  int fails = 0;

  // ack is a single cycle pulse
  a_ack_pulse: assert property (@(posedge bus) disable iff (ctl_rst)
    bus_ack |=> !bus_ack)
    else begin
      fails++;
      $error("bus_ack stayed high for more than one cycle");
    end

  // stalled output keeps its payload
  a_sto_hold: assert property (@(posedge bus) disable iff (ctl_rst)
    (sto_valid && !sto_ready) |=> $stable(sto_data))
    else begin
      fails++;
      $error("sto_data changed while stalled");
    end

  // lst pulse follows the final transfer
  a_lst_after: assert property (@(posedge bus) disable iff (ctl_rst)
    evn_lst |-> $past(sto_valid && sto_ready && sto_last))
    else begin
      fails++;
      $error("evn_lst without a last transfer one cycle before");
    end

endmodule

bind osc_top osc_assertions u_assert (
  .bus       (bus),
  .ctl_rst   (ctl_rst),
  .bus_ack   (bus_ack),
  .sto_data  (sto_data),
  .sto_valid (sto_valid),
  .sto_ready (sto_ready),
  .sto_last  (sto_last),
  .evn_lst   (evn_lst)
);

// ==== osc_checker.sv ====
// watches top ports only; data compare runs while chk_en is high and config is stable
`timescale 1ns/1ps
`include "osc_params.svh"

module osc_checker import osc_pkg::*; (
  input  logic               bus,
  input  logic               ctl_rst,
  input  logic               chk_en,
  input  logic               bus_wen,
  input  logic [`OSC_AW-1:0] bus_addr,
  input  logic [31:0]        bus_wdata,
  input  sample_t            sti_data,
  input  logic               sti_valid,
  input  logic               sti_ready,
  input  sample_t            sto_data,
  input  logic               sto_last,
  input  logic               sto_valid,
  input  logic               sto_ready,
  input  logic [`OSC_EW-1:0] evn_ext,
  output int                 errors,
  output int                 pending
);

  logic [`OSC_EW-1:0]  m_str;
  logic [`OSC_EW-1:0]  m_stp;
  logic [`OSC_EW-1:0]  m_trg;
  logic [`OSC_CW-1:0]  m_pst;
  logic [`OSC_DCW-1:0] m_dec;
  logic [`OSC_DSW-1:0] m_shr;
  logic                m_avg;
  logic                running;
  logic                rst_pend;
  logic                oxfer;
  logic                start_now;
  logic                stop_now;
  logic                trig_now;
  logic signed [32:0]  acc;
  int unsigned         gcnt;
  int unsigned         pcnt;
  sample_t             exp_q[$];
  sample_t             res;

  // event matrix as the masks select it
  assign start_now = |(evn_ext & m_str);
  assign stop_now  = |(evn_ext & m_stp);
  assign trig_now  = |(evn_ext & m_trg);
  assign oxfer     = sto_valid & sto_ready;

  initial errors = 0;

  ////////////////////
  // sequencer model
  ////////////////////

  always @(posedge bus) begin
    if (ctl_rst) begin
      {m_str, m_stp, m_trg, m_pst} <= '0;
      {m_dec, m_shr, m_avg} <= '0;
      running  <= 1'b0;
      rst_pend <= 1'b0;
      pcnt     <= 0;
    end else begin
      // snoop register writes
      if (bus_wen) begin
        case (bus_addr)
          `OSC_A_STR: m_str <= bus_wdata[`OSC_EW-1:0];
          `OSC_A_STP: m_stp <= bus_wdata[`OSC_EW-1:0];
          `OSC_A_TRG: m_trg <= bus_wdata[`OSC_EW-1:0];
          `OSC_A_PST: m_pst <= bus_wdata[`OSC_CW-1:0];
          `OSC_A_DEC: m_dec <= bus_wdata[`OSC_DCW-1:0];
          `OSC_A_SHR: m_shr <= bus_wdata[`OSC_DSW-1:0];
          `OSC_A_AVG: m_avg <= bus_wdata[0];
          default: ;
        endcase
      end
      rst_pend <= bus_wen && (bus_addr == `OSC_A_CTL) && bus_wdata[0];
      if (rst_pend)                  running <= 1'b0;
      else if (running && stop_now)  running <= 1'b0;
      else if (start_now)            running <= 1'b1;
      else if (oxfer && sto_last)    running <= 1'b0;
      if (sto_valid && !running) begin
        errors++;
        $display("output valid seen while the sequencer is idle");
      end
      // post transfers counted from the cycle after the trigger
      if (trig_now) begin
        pcnt <= 0;
      end else if (oxfer) begin
        if (sto_last && (pcnt != m_pst)) begin
          errors++;
          $display("CHECK FAILED post_count got %h expected %h", pcnt + 1, m_pst + 1);
        end
        pcnt <= pcnt + 1;
      end
    end
  end

  ////////////////////
  // decimation model
  ////////////////////

  always @(posedge bus) begin
    if (!chk_en) begin
      acc  = '0;
      gcnt = 0;
      exp_q.delete();
    end else begin
      if (oxfer) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("output transfer arrived with no expected sample");
        end else begin
          res = exp_q.pop_front();
          if (sto_data !== res) begin
            errors++;
            $display("CHECK FAILED sto_data got %h expected %h", sto_data, res);
          end
        end
      end
      if (sti_valid && sti_ready) begin
        acc = acc + 33'(sti_data);
        if (gcnt == m_dec) begin
          // group complete
          res = m_avg ? sample_t'(acc >>> m_shr) : sti_data;
          exp_q.push_back(res);
          acc  = '0;
          gcnt = 0;
        end else begin
          gcnt++;
        end
      end
    end
    pending <= exp_q.size();
  end

endmodule

// ==== tb_osc.sv ====
// event outputs loop back to evn_ext here; stimulus is fully random from seed 17
`timescale 1ns/1ps
`include "osc_params.svh"

module tb_clk (output logic clk);
  initial clk = 1'b0;
  // 4 ns period
  always #2 clk = ~clk;
endmodule

module tb_osc import osc_pkg::*; ();

  logic               bus, ctl_rst, bus_wen, bus_ren, bus_ack, irq;
  logic [`OSC_AW-1:0] bus_addr;
  logic [31:0]        bus_wdata, bus_rdata, rd, wv;
  sample_t            sti_data, sto_data;
  logic               sti_last, sti_valid, sti_ready, sto_last, sto_valid, sto_ready;
  logic [`OSC_EW-1:0] evn_ext;
  logic               evn_str, evn_stp, evn_trg, evn_lvl, evn_lst;
  logic               chk_en, gen_on, drv_busy;
  int                 errors, chk_errors, pending, lvl_cnt, lst_cnt, lvl0, lst0, total;
  sample_t            ramp_q[$];
  logic [`OSC_AW-1:0] reg_a[13];
  logic [31:0]        reg_m[13];

  tb_clk u_clk (.clk(bus));

  osc_top UUT (.*);

  osc_checker u_chk (
    .bus, .ctl_rst, .chk_en, .bus_wen, .bus_addr, .bus_wdata,
    .sti_data, .sti_valid, .sti_ready, .sto_data, .sto_last, .sto_valid, .sto_ready,
    .evn_ext, .errors(chk_errors), .pending
  );

  // closed event matrix
  assign evn_ext = {evn_lst, evn_lvl, evn_trg, evn_stp, evn_str};

  always @(posedge bus) begin
    if (evn_lvl) lvl_cnt <= lvl_cnt + 1;
    if (evn_lst) lst_cnt <= lst_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  ////////////////////
  // bus access
  ////////////////////

  task automatic wait_ack(output logic [31:0] d);
    int t;
    for (t = 0; t < 20; t++) begin
      @(posedge bus);
      if (bus_ack) break;
    end
    if (t == 20) abort_run("register bus never acknowledged the access");
    d = bus_rdata;
  endtask

  task automatic reg_write(input logic [`OSC_AW-1:0] a, input logic [31:0] d);
    logic [31:0] dummy;
    @(negedge bus);
    bus_wen   = 1'b1;
    bus_addr  = a;
    bus_wdata = d;
    @(negedge bus);
    bus_wen = 1'b0;
    wait_ack(dummy);
  endtask

  task automatic reg_read(input logic [`OSC_AW-1:0] a, output logic [31:0] d);
    @(negedge bus);
    bus_ren  = 1'b1;
    bus_addr = a;
    @(negedge bus);
    bus_ren = 1'b0;
    wait_ack(d);
  endtask

  task automatic wait_irq(input logic level);
    int t;
    for (t = 0; t < 50; t++) begin
      @(posedge bus);
      if (irq === level) break;
    end
    if (t == 50) abort_run("irq never reached the expected level");
  endtask

  task automatic wait_lst(input int n);
    int t;
    for (t = 0; t < 5000; t++) begin
      @(posedge bus);
      if (lst_cnt >= n) break;
    end
    if (t == 5000) abort_run("acquisition never delivered its last sample");
  endtask

  task automatic wait_drain();
    int t;
    for (t = 0; t < 2000; t++) begin
      @(posedge bus);
      if (!drv_busy && ramp_q.size() == 0 && pending == 0) break;
    end
    if (t == 2000) abort_run("stream did not drain");
  endtask

  // input stream, holds each sample until accepted
  initial begin
    int t;
    sti_valid = 1'b0;
    sti_data  = '0;
    sti_last  = 1'b0;
    drv_busy  = 1'b0;
    forever begin
      @(negedge bus);
      sti_valid = 1'b0;
      drv_busy  = 1'b0;
      if (ramp_q.size() > 0 || (gen_on && $urandom_range(3) != 0)) begin
        drv_busy  = 1'b1;
        sti_data  = (ramp_q.size() > 0) ? ramp_q.pop_front() : sample_t'($urandom);
        sti_last  = 1'($urandom_range(1));
        sti_valid = 1'b1;
        for (t = 0; t < 200; t++) begin
          @(posedge bus);
          if (sti_ready) break;
        end
        if (t == 200) abort_run("input sample was never accepted");
      end
    end
  end

  // random back-pressure
  always @(negedge bus) sto_ready <= ($urandom_range(3) != 0);

  initial begin
    #1000000;
    abort_run("simulation ran past its time limit");
  end

  initial begin
    void'($urandom(17));
    {ctl_rst, bus_wen, bus_ren, bus_addr, bus_wdata} = '0;
    ctl_rst   = 1'b1;
    sto_ready = 1'b1;
    {chk_en, gen_on, errors, lvl_cnt, lst_cnt} = '0;
    reg_a = '{`OSC_A_STR, `OSC_A_STP, `OSC_A_TRG, `OSC_A_IEN, `OSC_A_PRE, `OSC_A_PST,
              `OSC_A_POS, `OSC_A_NEG, `OSC_A_EDG, `OSC_A_HLD, `OSC_A_DEC, `OSC_A_SHR,
              `OSC_A_AVG};
    reg_m = '{32'h1f, 32'h1f, 32'h1f, 32'h7, 32'h7fffffff, 32'h7fffffff, 32'hffff,
              32'hffff, 32'h1, 32'h7fffffff, 32'h1ffff, 32'hf, 32'h1};
    repeat (5) @(posedge bus);
    @(negedge bus);
    ctl_rst = 1'b0;

    // register readback
    for (int i = 0; i < 13; i++) begin
      wv = $urandom;
      reg_write(reg_a[i], wv);
      reg_read(reg_a[i], rd);
      check_eq("bus_rdata", rd, wv & reg_m[i]);
    end

    // sw sources: start bit0, stop bit1, trig bit2
    reg_write(`OSC_A_STR, 32'h1);
    reg_write(`OSC_A_STP, 32'h2);
    reg_write(`OSC_A_TRG, 32'h4);
    reg_write(`OSC_A_IEN, 32'h0);
    reg_write(`OSC_A_PRE, 32'h0);

    ////////////////////
    // decimation, free-running acquisition
    ////////////////////
    for (int it = 0; it < 4; it++) begin
      reg_write(`OSC_A_DEC, $urandom_range(5));
      reg_write(`OSC_A_SHR, $urandom_range(3));
      reg_write(`OSC_A_AVG, it % 2);
      reg_write(`OSC_A_CTL, 32'h1);
      reg_write(`OSC_A_CTL, 32'h2);
      repeat (3) @(posedge bus);
      @(negedge bus);
      chk_en = 1'b1;
      gen_on = 1'b1;
      repeat (300) @(posedge bus);
      gen_on = 1'b0;
      wait_drain();
      chk_en = 1'b0;
      reg_write(`OSC_A_CTL, 32'h4);
    end

    // pre/post counting, early trigger ignored
    reg_write(`OSC_A_DEC, 32'h0);
    reg_write(`OSC_A_AVG, 32'h0);
    reg_write(`OSC_A_PRE, 32'd12);
    reg_write(`OSC_A_PST, $urandom_range(7));
    reg_write(`OSC_A_CTL, 32'h1);
    reg_write(`OSC_A_CTL, 32'h2);
    gen_on = 1'b1;
    reg_write(`OSC_A_CTL, 32'h8);
    reg_read(`OSC_A_CTL, rd);
    check_eq("sts_trg", rd[3], 1'b0);
    rd = '0;
    for (int t = 0; t < 200 && rd < 12; t++) reg_read(`OSC_A_SPRE, rd);
    if (rd < 12) abort_run("pre-trigger count never reached its limit");
    lst0 = lst_cnt;
    reg_write(`OSC_A_CTL, 32'h8);
    wait_lst(lst0 + 1);
    reg_read(`OSC_A_CTL, rd);
    check_eq("ctl_status", rd, 32'hc);
    gen_on = 1'b0;
    wait_drain();

    // level trigger with hold-off
    reg_write(`OSC_A_TRG, 32'h8);
    reg_write(`OSC_A_PRE, 32'h0);
    reg_write(`OSC_A_PST, 32'h3);
    reg_write(`OSC_A_POS, 32'd100);
    reg_write(`OSC_A_NEG, 32'hffffff9c);
    reg_write(`OSC_A_EDG, 32'h0);
    reg_write(`OSC_A_HLD, 32'd6);
    reg_write(`OSC_A_CTL, 32'h1);
    reg_write(`OSC_A_CTL, 32'h2);
    reg_read(`OSC_A_CTL, rd);
    check_eq("sts_str", rd[1], 1'b1);
    lvl0 = lvl_cnt;
    lst0 = lst_cnt;
    for (int k = 0; k < 5; k++) begin
      ramp_q.push_back(-16'sd200);
      ramp_q.push_back(16'sd200);
    end
    wait_lst(lst0 + 1);
    wait_drain();
    repeat (4) @(posedge bus);
    check_eq("evn_lvl_count", lvl_cnt - lvl0, 2);

    ////////////////////
    // interrupts and status reset
    ////////////////////
    reg_write(`OSC_A_TRG, 32'h4);
    reg_write(`OSC_A_IEN, 32'h2);
    reg_write(`OSC_A_IST, 32'h7);
    reg_write(`OSC_A_CTL, 32'h2);
    reg_read(`OSC_A_IST, rd);
    check_eq("irq_sts", rd, 32'h1);
    check_eq("irq", irq, 1'b0);
    reg_write(`OSC_A_CTL, 32'h8);
    reg_read(`OSC_A_IST, rd);
    check_eq("irq_sts", rd, 32'h5);
    check_eq("irq", irq, 1'b0);
    reg_write(`OSC_A_CTL, 32'h4);
    wait_irq(1'b1);
    reg_read(`OSC_A_IST, rd);
    check_eq("irq_sts", rd, 32'h7);
    reg_write(`OSC_A_IST, 32'h7);
    wait_irq(1'b0);
    reg_read(`OSC_A_CTL, rd);
    check_eq("ctl_status", rd, 32'hc);
    reg_write(`OSC_A_CTL, 32'h1);
    reg_read(`OSC_A_CTL, rd);
    check_eq("ctl_status", rd, 32'h0);
    reg_read(`OSC_A_IST, rd);
    check_eq("irq_sts", rd, 32'h0);

    repeat (4) @(posedge bus);
    total = errors + chk_errors + UUT.u_assert.fails;
    $display("errors: testbench %0d checker %0d assertions %0d",
             errors, chk_errors, UUT.u_assert.fails);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
osc_pkg.sv
osc_if.sv
osc_regset.sv
osc_decimator.sv
osc_edge.sv
osc_acq.sv
osc_top.sv
osc_assertions.sv
osc_checker.sv
tb_osc.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_osc -f all.f -o sim_osc
./obj_dir/sim_osc +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
else
  exit 1
fi
